// ==== Bender.yml ====
package:
  name: console_top

sources:
  - files:
      - console_pkg.sv
      - uart_rx.sv
      - uart_tx.sv
      - com_link.sv
      - console_com.sv
      - cmd_engine.sv
      - console_top.sv
  - target: test
    files:
      - console_asserts.sv
      - console_tb.sv

// ==== cmd_engine.sv ====
`timescale 1ns/100ps

module cmd_engine (
    input  logic        clk,
    input  logic        rst,
    output logic        fs_read,
    input  logic        fd_read,
    output logic [3:0]  read_btype,
    input  logic [15:0] device_cmd,
    input  logic        fs_send,
    output logic        fd_send,
    input  logic [3:0]  send_btype,
    output logic [7:0]  rd_data,
    output logic        rd_valid
);

    logic       enable;
    logic       exec;
    logic       fd_read_q;
    logic [3:0] opcode;
    logic [3:0] addr;
    logic [7:0] regs [console_pkg::NUM_REGS];

    assign opcode = device_cmd[15:12];
    assign addr   = device_cmd[11:8];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            fs_read    <= 1'b0;
            read_btype <= console_pkg::COM_INIT;
            exec       <= 1'b0;
            fd_read_q  <= 1'b0;
            enable     <= 1'b1;
            fd_send    <= 1'b0;
            rd_valid   <= 1'b0;
        end else begin
            fd_read_q <= fd_read;
            exec      <= 1'b0;
            rd_valid  <= exec && (opcode == console_pkg::OP_READ);
            if (fs_read && fd_read) begin
                fs_read <= 1'b0;
                exec    <= 1'b1;
            end else if (!fs_read && enable && !exec && !fd_read && !fd_read_q &&
                         !fs_send && !fd_send) begin
                fs_read    <= 1'b1; // Quiet gap lets a pending send in first.
                read_btype <= console_pkg::COM_READ;
            end
            fd_send <= fs_send;
            if (fd_send && !fs_send) begin
                if (send_btype == console_pkg::COM_STOP) enable <= 1'b0;
                else if (send_btype == console_pkg::COM_CONF) enable <= 1'b1;
            end
        end
    end

    // Register file.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < console_pkg::NUM_REGS; i++) begin
                regs[i] <= 8'h00;
            end
        end else if (exec && opcode == console_pkg::OP_WRITE) begin
            regs[addr] <= device_cmd[7:0];
        end
    end

    always_ff @(posedge clk) begin
        if (exec && opcode == console_pkg::OP_READ) begin
            rd_data <= regs[addr];
        end
    end

endmodule

// ==== com_link.sv ====
`timescale 1ns/100ps

module com_link (
    input  logic        clk,
    input  logic        rst,
    input  logic [7:0]  rx_data,
    input  logic        rx_valid,
    output logic [7:0]  tx_data,
    output logic        tx_start,
    input  logic        tx_busy,
    input  logic        fs_com_read,
    input  logic [3:0]  com_read_btype,
    output logic        fd_com_read,
    output logic [15:0] com_cmd,
    output logic        fs_com_send,
    output logic [3:0]  com_send_btype,
    input  logic        fd_com_send
);

    logic [1:0] pos;
    logic [7:0] cmd_hi;
    logic [3:0] hdr;
    logic       fs_read_q;
    logic       prompt_pend;

    assign hdr = rx_data[7:4];

    // Prompt byte carries the requested block type.
    assign tx_data = {com_read_btype, 4'h0};

    // --------------------
    // Incoming frames
    // --------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pos            <= 2'd0;
            fd_com_read    <= 1'b0;
            fs_com_send    <= 1'b0;
            com_send_btype <= console_pkg::COM_INIT;
        end else begin
            if (rx_valid) begin
                case (pos)
                    2'd0: begin
                        if (hdr == console_pkg::COM_DATA) begin
                            pos <= 2'd1;
                        end else if ((hdr == console_pkg::COM_CONF ||
                                      hdr == console_pkg::COM_STOP) && !fs_com_send) begin
                            fs_com_send    <= 1'b1;
                            com_send_btype <= hdr;
                        end
                    end
                    2'd1: pos <= 2'd2;
                    default: begin
                        pos <= 2'd0;
                        if (fs_com_read) begin
                            fd_com_read <= 1'b1;
                        end // No request open, frame dropped.
                    end
                endcase
            end
            if (!fs_com_read) begin
                fd_com_read <= 1'b0;
            end
            if (fd_com_send) begin
                fs_com_send <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rx_valid && pos == 2'd1) begin
            cmd_hi <= rx_data;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            com_cmd <= console_pkg::CMD_INIT;
        end else if (rx_valid && pos == 2'd2) begin
            com_cmd <= {cmd_hi, rx_data};
        end
    end

    // --------------------
    // Prompt on each new read
    // --------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            fs_read_q   <= 1'b0;
            prompt_pend <= 1'b0;
            tx_start    <= 1'b0;
        end else begin
            fs_read_q <= fs_com_read;
            tx_start  <= 1'b0;
            if (fs_com_read && !fs_read_q) begin
                prompt_pend <= 1'b1;
            end else if (prompt_pend && !tx_busy && !tx_start) begin
                prompt_pend <= 1'b0;
                tx_start    <= 1'b1;
            end
        end
    end

endmodule

// ==== console_asserts.sv ====
`timescale 1ns/100ps

module console_asserts (
    input logic clk,
    input logic rst,
    input logic fs_com_read,
    input logic fs_send,
    input logic fs_read,
    input logic fd_read,
    input logic fs_com_send,
    input logic fd_com_send
);

    // Read and send paths never overlap.
    assert property (@(posedge clk) disable iff (rst) !(fs_com_read && fs_send))
        else $error("fs_com_read and fs_send high together");

    assert property (@(posedge clk) disable iff (rst) fd_read |-> $past(fs_read))
        else $error("fd_read without a preceding fs_read");

    assert property (@(posedge clk) disable iff (rst) $rose(fd_com_send) |-> fs_com_send)
        else $error("fd_com_send rose while fs_com_send was low");

endmodule

bind console_com console_asserts u_asserts (
    .clk(clk), .rst(rst), .fs_com_read(fs_com_read), .fs_send(fs_send),
    .fs_read(fs_read), .fd_read(fd_read), .fs_com_send(fs_com_send),
    .fd_com_send(fd_com_send)
);

// ==== console_com.sv ====
`timescale 1ns/100ps

module console_com (
    input  logic        clk,
    input  logic        rst,

    input  logic        fs_com_send,
    output logic        fd_com_send,
    output logic        fs_com_read,
    input  logic        fd_com_read,

    input  logic [3:0]  com_send_btype,
    output logic [3:0]  com_read_btype,

    output logic        fs_send,
    input  logic        fd_send,
    input  logic        fs_read,
    output logic        fd_read,

    output logic [3:0]  send_btype,
    input  logic [3:0]  read_btype,

    input  logic [15:0] com_cmd,
    output logic [15:0] device_cmd
);

    typedef enum logic [7:0] {
        MAIN_IDLE = 8'h00,
        MAIN_WAIT = 8'h01,
        READ_IDLE = 8'h40,
        READ_WAIT = 8'h41,
        READ_WORK = 8'h42,
        READ_DONE = 8'h43,
        SEND_IDLE = 8'h80,
        SEND_WAIT = 8'h81,
        SEND_WORK = 8'h82,
        SEND_DONE = 8'h83
    } state_t;

    state_t state, next_state;

    assign fs_com_read = (state == READ_IDLE) || (state == READ_WAIT) || (state == READ_WORK);
    assign fd_read     = (state == READ_DONE);
    assign fs_send     = (state == SEND_IDLE) || (state == SEND_WAIT) || (state == SEND_WORK);
    assign fd_com_send = (state == SEND_DONE);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= MAIN_IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            MAIN_IDLE: next_state = MAIN_WAIT;
            MAIN_WAIT: begin
                if (fs_read) begin // Device reads take priority.
                    next_state = READ_IDLE;
                end else if (fs_com_send) begin
                    next_state = SEND_IDLE;
                end
            end
            // --------------------
            READ_IDLE: next_state = READ_WAIT;
            READ_WAIT: next_state = READ_WORK;
            READ_WORK: if (fd_com_read) next_state = READ_DONE;
            READ_DONE: if (!fs_read) next_state = MAIN_WAIT;
            // --------------------
            SEND_IDLE: next_state = SEND_WAIT;
            SEND_WAIT: next_state = SEND_WORK;
            SEND_WORK: if (fd_send) next_state = SEND_DONE;
            SEND_DONE: if (!fs_com_send) next_state = MAIN_WAIT;
            default:   next_state = MAIN_IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            com_read_btype <= console_pkg::COM_INIT;
            send_btype     <= console_pkg::COM_INIT;
        end else if (state == MAIN_IDLE) begin
            com_read_btype <= console_pkg::COM_INIT;
            send_btype     <= console_pkg::COM_INIT;
        end else begin
            if (state == READ_WAIT) com_read_btype <= read_btype;
            if (state == SEND_WAIT) send_btype <= com_send_btype;
        end
    end

    // Taken with fd_com_read so the command is the one just framed.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            device_cmd <= console_pkg::CMD_INIT;
        end else if (state == MAIN_IDLE) begin
            device_cmd <= console_pkg::CMD_INIT;
        end else if (state == READ_WORK && fd_com_read) begin
            device_cmd <= com_cmd;
        end
    end

endmodule

// ==== console_pkg.sv ====
package console_pkg;

    // --------------------
    // Block types
    // --------------------
    localparam logic [3:0] COM_INIT = 4'h0;
    localparam logic [3:0] COM_CONF = 4'h1;
    localparam logic [3:0] COM_READ = 4'h4;
    localparam logic [3:0] COM_DATA = 4'h5;
    localparam logic [3:0] COM_STOP = 4'h9;
    localparam logic [3:0] COM_STAT = 4'hA;

    // --------------------
    // Command word
    // --------------------
    // Bits 15:12 opcode, 11:8 register address, 7:0 data.
    localparam logic [15:0] CMD_INIT = 16'h0000;

    localparam logic [3:0] OP_WRITE = 4'h1;
    localparam logic [3:0] OP_READ  = 4'h2;

    localparam int NUM_REGS = 16;

    // --------------------
    // Serial line
    // --------------------
    localparam int CLKS_PER_BIT = 4; // Clock cycles per UART bit.

endpackage

// ==== console_tb.sv ====
`timescale 1ns/100ps

module console_tb;

    logic        clk;
    logic        rst;
    logic        rxd;
    logic        txd;
    logic [7:0]  rd_data;
    logic        rd_valid;

    // Stimulus table, one entry per test.
    bit          t_data   [32]; // DATA frame, else one header byte.
    logic [15:0] t_word   [32];
    int          t_exp_rd [32]; // -1 when no rd_valid is due.
    bit          t_prompt [32];
    int          n_tests;

    logic [7:0]  model [console_pkg::NUM_REGS];
    logic [3:0]  wr_addr [8];
    logic [31:0] rand_state;
    logic [7:0]  tx_bytes [$];
    logic [7:0]  rd_seen [$];
    int          errors;
    int          failed_tests;
    int          start_errs;
    int          cycles = 0;
    int          limit = 0;

    console_top dut (
        .clk(clk), .rst(rst), .rxd(rxd), .txd(txd),
        .rd_data(rd_data), .rd_valid(rd_valid)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] next_random(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // --------------------
    // Table building
    // --------------------
    task automatic add_cmd(input logic [3:0] op, input logic [3:0] addr,
                           input logic [7:0] data, input bit prompt);
        t_data[n_tests]   = 1'b1;
        t_word[n_tests]   = {op, addr, data};
        t_prompt[n_tests] = prompt;
        t_exp_rd[n_tests] = -1;
        if (op == console_pkg::OP_READ) begin
            t_exp_rd[n_tests] = int'(model[addr]);
        end else if (op == console_pkg::OP_WRITE) begin
            model[addr] = data;
        end
        n_tests++;
    endtask

    task automatic add_header(input logic [7:0] b, input bit prompt);
        t_data[n_tests]   = 1'b0;
        t_word[n_tests]   = {8'h00, b};
        t_prompt[n_tests] = prompt;
        t_exp_rd[n_tests] = -1;
        n_tests++;
    endtask

    // --------------------
    // Serial side
    // --------------------
    task automatic send_byte(input logic [7:0] b);
        logic [9:0] frame;
        frame = {1'b1, b, 1'b0}; // Stop, data, start.
        for (int i = 0; i < 10; i++) begin
            rxd = frame[i];
            repeat (console_pkg::CLKS_PER_BIT) @(negedge clk);
        end
    endtask

    initial begin : txd_monitor
        logic [7:0] b;
        @(negedge rst);
        forever begin
            @(negedge clk);
            if (!txd) begin
                repeat (console_pkg::CLKS_PER_BIT / 2) @(negedge clk); // Mid start bit.
                for (int i = 0; i < 8; i++) begin
                    repeat (console_pkg::CLKS_PER_BIT) @(negedge clk);
                    b[i] = txd;
                end
                repeat (console_pkg::CLKS_PER_BIT) @(negedge clk);
                assert (txd === 1'b1) else begin
                    $display("%0t: stop bit on txd is not high", $time);
                    errors++;
                end
                tx_bytes.push_back(b);
            end
        end
    end

    always @(negedge clk) begin
        if (rd_valid === 1'b1) rd_seen.push_back(rd_data);
    end

    // --------------------
    // Checks
    // --------------------
    task automatic check_prompt();
        int n;
        n = 0;
        while (tx_bytes.size() == 0 && n < 3 * 10 * console_pkg::CLKS_PER_BIT) begin
            @(negedge clk);
            n++;
        end
        assert (tx_bytes.size() == 1) else begin
            $display("%0t: expected one prompt byte on txd, saw %0d", $time, tx_bytes.size());
            errors++;
        end
        if (tx_bytes.size() > 0) begin
            assert (tx_bytes[0] === {console_pkg::COM_READ, 4'h0}) else begin
                $display("mismatch at %0t: txd byte got %02h expected %02h",
                         $time, tx_bytes[0], {console_pkg::COM_READ, 4'h0});
                errors++;
            end
        end
        tx_bytes.delete();
    endtask

    // No prompt may show up for several frame times.
    task automatic check_quiet();
        repeat (3 * 10 * console_pkg::CLKS_PER_BIT) @(negedge clk);
        assert (tx_bytes.size() == 0) else begin
            $display("%0t: a byte appeared on txd where no prompt was due", $time);
            errors++;
        end
        tx_bytes.delete();
    endtask

    task automatic check_rd(input int exp);
        if (exp >= 0) begin
            assert (rd_seen.size() == 1) else begin
                $display("%0t: expected one rd_valid pulse, saw %0d", $time, rd_seen.size());
                errors++;
            end
            if (rd_seen.size() > 0) begin
                assert (rd_seen[0] === exp[7:0]) else begin
                    $display("mismatch at %0t: rd_data got %02h expected %02h",
                             $time, rd_seen[0], exp[7:0]);
                    errors++;
                end
            end
        end else begin
            assert (rd_seen.size() == 0) else begin
                $display("%0t: rd_valid pulsed where no read was due", $time);
                errors++;
            end
        end
        rd_seen.delete();
    endtask

    task automatic report(input int idx, input logic [15:0] word);
        if (errors == start_errs) begin
            $display("test %0d (%04h): ok", idx, word);
        end else begin
            $display("test %0d (%04h): FAILED", idx, word);
            failed_tests++;
        end
    endtask

    // Four frames per test, plus margin for reset and quiet windows.
    initial begin
        wait (limit > 0);
        while (cycles < limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: run did not finish within %0d cycles", limit);
        $display("Checks failed");
        $finish;
    end

    initial begin
        rst = 1'b1;
        rxd = 1'b1;
        errors = 0;
        failed_tests = 0;
        n_tests = 0;
        rand_state = 32'h3e1d;
        for (int i = 0; i < console_pkg::NUM_REGS; i++) model[i] = 8'h00;

        add_cmd(console_pkg::OP_WRITE, 4'h3, 8'hA5, 1'b1);
        add_cmd(console_pkg::OP_READ, 4'h3, 8'h00, 1'b1);
        add_cmd(console_pkg::OP_READ, 4'h9, 8'h00, 1'b1); // Never written.
        add_cmd(4'h7, 4'h3, 8'h11, 1'b1);                 // Unknown opcode.
        add_cmd(console_pkg::OP_READ, 4'h3, 8'h00, 1'b1);
        add_header(8'h70, 1'b0);                          // Unknown block type.
        add_cmd(console_pkg::OP_WRITE, 4'hC, 8'h3C, 1'b1);
        add_cmd(console_pkg::OP_READ, 4'hC, 8'h00, 1'b1); // Framing still aligned.
        for (int i = 0; i < 8; i++) begin
            rand_state = next_random(rand_state);
            wr_addr[i] = rand_state[19:16];
            add_cmd(console_pkg::OP_WRITE, wr_addr[i], rand_state[27:20], 1'b1);
            rand_state = next_random(rand_state);
            add_cmd(console_pkg::OP_READ, wr_addr[int'(rand_state[23:16]) % (i + 1)],
                    8'h00, 1'b1);
        end
        add_header({console_pkg::COM_STOP, 4'h0}, 1'b0);
        add_cmd(console_pkg::OP_READ, 4'h3, 8'h00, 1'b0); // Last fetch before the stop.
        add_header({console_pkg::COM_CONF, 4'h0}, 1'b1);
        add_cmd(console_pkg::OP_WRITE, 4'h5, 8'h5A, 1'b1);
        add_cmd(console_pkg::OP_READ, 4'h5, 8'h00, 1'b1);
        limit = (4 * n_tests + 40) * 10 * console_pkg::CLKS_PER_BIT;

        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        start_errs = errors;
        assert (txd === 1'b1) else begin
            $display("mismatch at %0t: txd got %b expected 1", $time, txd);
            errors++;
        end
        check_prompt();
        check_rd(-1);
        report(0, 16'h0000);

        for (int t = 0; t < n_tests; t++) begin
            start_errs = errors;
            if (t_data[t]) begin
                send_byte({console_pkg::COM_DATA, 4'h0});
                send_byte(t_word[t][15:8]);
                send_byte(t_word[t][7:0]);
            end else begin
                send_byte(t_word[t][7:0]);
            end
            if (t_prompt[t]) check_prompt();
            else check_quiet();
            check_rd(t_exp_rd[t]);
            report(t + 1, t_word[t]);
        end

        $display("%0d tests, %0d failed, %0d errors", n_tests + 1, failed_tests, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// ==== console_top.f ====
console_pkg.sv
uart_rx.sv
uart_tx.sv
com_link.sv
console_com.sv
cmd_engine.sv
console_top.sv
console_asserts.sv
console_tb.sv

// ==== console_top.sv ====
`timescale 1ns/100ps

module console_top (
    input  logic       clk,
    input  logic       rst,
    input  logic       rxd,
    output logic       txd,
    output logic [7:0] rd_data,
    output logic       rd_valid
);

    logic [7:0]  rx_data;
    logic        rx_valid;
    logic [7:0]  tx_data;
    logic        tx_start;
    logic        tx_busy;

    // Link side.
    logic        fs_com_read;
    logic        fd_com_read;
    logic [3:0]  com_read_btype;
    logic [15:0] com_cmd;
    logic        fs_com_send;
    logic        fd_com_send;
    logic [3:0]  com_send_btype;

    // Device side.
    logic        fs_read;
    logic        fd_read;
    logic [3:0]  read_btype;
    logic [15:0] device_cmd;
    logic        fs_send;
    logic        fd_send;
    logic [3:0]  send_btype;

    uart_rx u_rx (
        .clk(clk), .rst(rst), .rxd(rxd), .rx_data(rx_data), .rx_valid(rx_valid)
    );

    uart_tx u_tx (
        .clk(clk), .rst(rst), .tx_start(tx_start), .tx_data(tx_data),
        .txd(txd), .tx_busy(tx_busy)
    );

    com_link u_link (
        .clk(clk), .rst(rst), .rx_data(rx_data), .rx_valid(rx_valid),
        .tx_data(tx_data), .tx_start(tx_start), .tx_busy(tx_busy),
        .fs_com_read(fs_com_read), .com_read_btype(com_read_btype),
        .fd_com_read(fd_com_read), .com_cmd(com_cmd), .fs_com_send(fs_com_send),
        .com_send_btype(com_send_btype), .fd_com_send(fd_com_send)
    );

    console_com u_com (
        .clk(clk), .rst(rst), .fs_com_send(fs_com_send), .fd_com_send(fd_com_send),
        .fs_com_read(fs_com_read), .fd_com_read(fd_com_read),
        .com_send_btype(com_send_btype), .com_read_btype(com_read_btype),
        .fs_send(fs_send), .fd_send(fd_send), .fs_read(fs_read), .fd_read(fd_read),
        .send_btype(send_btype), .read_btype(read_btype),
        .com_cmd(com_cmd), .device_cmd(device_cmd)
    );

    cmd_engine u_engine (
        .clk(clk), .rst(rst), .fs_read(fs_read), .fd_read(fd_read),
        .read_btype(read_btype), .device_cmd(device_cmd), .fs_send(fs_send),
        .fd_send(fd_send), .send_btype(send_btype), .rd_data(rd_data),
        .rd_valid(rd_valid)
    );

endmodule

// ==== uart_rx.sv ====
`timescale 1ns/100ps

module uart_rx (
    input  logic       clk,
    input  logic       rst,
    input  logic       rxd,
    output logic [7:0] rx_data,
    output logic       rx_valid
);

    logic [1:0] rxd_sync;
    logic       rxd_s;
    logic       active;
    logic [$clog2(console_pkg::CLKS_PER_BIT)-1:0] cnt;
    logic [3:0] bit_idx;
    logic [7:0] shreg;
    logic       mid_bit;

    assign rxd_s   = rxd_sync[1];
    assign mid_bit = active && (cnt == console_pkg::CLKS_PER_BIT / 2 - 1);

    // Control: start detect, bit pacing, end of frame.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rxd_sync <= 2'b11;
            active   <= 1'b0;
            cnt      <= '0;
            bit_idx  <= 4'd0;
            rx_valid <= 1'b0;
        end else begin
            rxd_sync <= {rxd_sync[0], rxd};
            rx_valid <= 1'b0;
            if (!active) begin
                if (!rxd_s) begin // Falling edge of start bit.
                    active  <= 1'b1;
                    cnt     <= '0;
                    bit_idx <= 4'd0;
                end
            end else begin
                if (cnt == console_pkg::CLKS_PER_BIT - 1) begin
                    cnt     <= '0;
                    bit_idx <= bit_idx + 4'd1;
                end else begin
                    cnt <= cnt + 1'b1;
                end
                if (mid_bit) begin
                    if (bit_idx == 4'd0 && rxd_s) begin
                        active <= 1'b0; // Glitch, not a start bit.
                    end else if (bit_idx == 4'd9) begin
                        active   <= 1'b0;
                        rx_valid <= 1'b1;
                    end
                end
            end
        end
    end

    // Data bits arrive LSB first.
    always_ff @(posedge clk) begin
        if (mid_bit) begin
            if (bit_idx >= 4'd1 && bit_idx <= 4'd8) begin
                shreg <= {rxd_s, shreg[7:1]};
            end
            if (bit_idx == 4'd9) begin
                rx_data <= shreg;
            end
        end
    end

endmodule

// ==== uart_tx.sv ====
`timescale 1ns/100ps

module uart_tx (
    input  logic       clk,
    input  logic       rst,
    input  logic       tx_start,
    input  logic [7:0] tx_data,
    output logic       txd,
    output logic       tx_busy
);

    logic [9:0] shreg;
    logic [$clog2(console_pkg::CLKS_PER_BIT)-1:0] cnt;
    logic [3:0] bit_idx;

    assign txd = shreg[0]; // Line idles high.

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            shreg   <= '1;
            cnt     <= '0;
            bit_idx <= 4'd0;
            tx_busy <= 1'b0;
        end else if (!tx_busy) begin
            if (tx_start) begin
                shreg   <= {1'b1, tx_data, 1'b0}; // Stop, data, start.
                cnt     <= '0;
                bit_idx <= 4'd0;
                tx_busy <= 1'b1;
            end
        end else begin
            if (cnt == console_pkg::CLKS_PER_BIT - 1) begin
                cnt   <= '0;
                shreg <= {1'b1, shreg[9:1]};
                if (bit_idx == 4'd9) begin
                    tx_busy <= 1'b0; // End of stop bit.
                end else begin
                    bit_idx <= bit_idx + 4'd1;
                end
            end else begin
                cnt <= cnt + 1'b1;
            end
        end
    end

endmodule
